/* ram_ctrl_pkg.sv */
// memory controller shared types

package ram_ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // widths with a meaning
   ////////////////////////////////////////////////////////////

   // cpu main-memory word address
   typedef logic [21:0] sdram_addr_t;
   // data word, main memory and video ram
   typedef logic [31:0] mem_word_t;
   // video ram word address, 32k words
   typedef logic [14:0] vram_addr_t;
   // byte address on the application interface
   typedef logic [27:0] app_addr_t;
   // application command code
   typedef logic [2:0]  app_cmd_t;

   ////////////////////////////////////////////////////////////
   // main-memory port states
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      SD_IDLE,
      SD_READ,
      SD_READBSY,
      SD_READW,
      SD_WRITE,
      SD_WRITEBSY,
      SD_WRITEW
   } sd_state_t;

   // application command codes
   localparam app_cmd_t APP_CMD_WRITE = 3'b000;
   localparam app_cmd_t APP_CMD_READ  = 3'b001;

   // upper word address bits that must be zero for real memory
   localparam int MEM_LIMIT_BITS = 5;

   // returned for reads outside the fitted memory
   localparam mem_word_t UNMAPPED_WORD = 32'hffff_ffff;

endpackage

/* dram_init_seq.sv */
// memory core reset sequencer
`timescale 1ns/1ps

module dram_init_seq import ram_ctrl_pkg::*; #(
   parameter int unsigned RESET_CYCLES = 65535
) (
   input  logic clk,
   input  logic reset,
   input  logic lpddr_reset,
   input  logic app_rdy,
   input  logic init_calib_complete,
   output logic dram_sys_rst,
   output logic calib_done
);

   // counter wide enough to hold the load value
   localparam int CNT_W = $clog2(RESET_CYCLES + 1);
   localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(RESET_CYCLES);

   logic [CNT_W-1:0] rst_cnt;
   logic             ready_seen;

   ////////////////////////////////////////////////////////////
   // core reset hold-off
   ////////////////////////////////////////////////////////////

   // reload while lpddr_reset is held, then count down to zero
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rst_cnt <= CNT_LOAD;
      end else if (lpddr_reset) begin
         rst_cnt <= CNT_LOAD;
      end else if (rst_cnt != '0) begin
         rst_cnt <= rst_cnt - 1'b1;
      end
   end

   // core stays in reset until the count runs out
   assign dram_sys_rst = (rst_cnt != '0);

   ////////////////////////////////////////////////////////////
   // calibration status
   ////////////////////////////////////////////////////////////

   // sticky once the core has accepted anything
   // app_rdy means nothing while the core is still held in reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_seen <= 1'b0;
      end else if (lpddr_reset) begin
         ready_seen <= 1'b0;
      end else if (app_rdy && !dram_sys_rst) begin
         ready_seen <= 1'b1;
      end
   end

   assign calib_done = init_calib_complete | ready_seen;

   // software must never see usable memory with the core in reset
   a_no_calib_in_reset : assert property (
      @(posedge clk) disable iff (reset) dram_sys_rst |-> !calib_done);

endmodule

/* sdram_port.sv */
// main-memory port bridge
`timescale 1ns/1ps

module sdram_port import ram_ctrl_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   // cpu side
   input  sdram_addr_t sdram_addr,
   input  mem_word_t   sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output mem_word_t   sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,
   // application interface
   input  logic        app_rdy,
   input  logic        app_wdf_rdy,
   input  mem_word_t   app_rd_data,
   input  logic        app_rd_data_valid,
   output app_addr_t   app_addr,
   output app_cmd_t    app_cmd,
   output logic        app_en,
   output mem_word_t   app_wdf_data,
   output logic        app_wdf_wren
);

   sd_state_t state;
   sd_state_t state_next;
   logic      unmapped;

   // any of the top address bits set means no memory there
   assign unmapped = |sdram_addr[$bits(sdram_addr_t)-1 -: MEM_LIMIT_BITS];

   ////////////////////////////////////////////////////////////
   // port FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= SD_IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      unique case (state)
         SD_IDLE: begin
            // read wins if both levels show up
            if (sdram_req) begin
               state_next = SD_READ;
            end else if (sdram_write) begin
               state_next = SD_WRITE;
            end
         end
         // wait out back-pressure and issue on the exit edge
         SD_READ:     if (app_rdy) state_next = SD_READBSY;
         SD_READBSY:  if (app_rd_data_valid) state_next = SD_READW;
         // hold until the cpu drops its level
         SD_READW:    if (!sdram_req) state_next = SD_IDLE;
         SD_WRITE:    if (app_rdy && app_wdf_rdy) state_next = SD_WRITEBSY;
         SD_WRITEBSY: state_next = SD_WRITEW;
         SD_WRITEW:   if (!sdram_write) state_next = SD_IDLE;
         default:     state_next = SD_IDLE;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // application commands
   ////////////////////////////////////////////////////////////

   // word address to byte address for 32-bit words
   assign app_addr     = {4'b0000, sdram_addr, 2'b00};
   assign app_cmd      = (state == SD_WRITE) ? APP_CMD_WRITE : APP_CMD_READ;
   assign app_wdf_data = sdram_data_in;

   // one command per request with the write data riding along
   assign app_en = ((state == SD_READ) && app_rdy) ||
                   ((state == SD_WRITE) && app_rdy && app_wdf_rdy);
   assign app_wdf_wren = (state == SD_WRITE) && app_rdy && app_wdf_rdy;

   ////////////////////////////////////////////////////////////
   // read data and completions
   ////////////////////////////////////////////////////////////

   // latch returned word or all ones past the end of memory
   always_ff @(posedge clk) begin
      if ((state == SD_READBSY) && app_rd_data_valid) begin
         sdram_data_out <= unmapped ? UNMAPPED_WORD : app_rd_data;
      end
   end

   // completions only while the cpu still holds its level
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         sdram_ready <= 1'b0;
         sdram_done  <= 1'b0;
      end else begin
         sdram_ready <= (state == SD_READW) && sdram_req;
         sdram_done  <= (state == SD_WRITEW) && sdram_write;
      end
   end

   // read data only comes back for the one outstanding read
   a_rd_in_busy : assert property (
      @(posedge clk) disable iff (reset)
      app_rd_data_valid |-> (state == SD_READBSY));

   // cpu never asks for a read and a write at once
   a_one_level : assert property (
      @(posedge clk) disable iff (reset)
      (state == SD_IDLE) |-> !(sdram_req && sdram_write));

endmodule

/* vram_dual_port.sv */
// dual-port video ram
`timescale 1ns/1ps

module vram_dual_port import ram_ctrl_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   // cpu port
   input  vram_addr_t vram_cpu_addr,
   input  mem_word_t  vram_cpu_data_in,
   input  logic       vram_cpu_req,
   input  logic       vram_cpu_write,
   output mem_word_t  vram_cpu_data_out,
   output logic       vram_cpu_ready,
   // display port
   input  vram_addr_t vram_vga_addr,
   input  logic       vram_vga_req,
   output mem_word_t  vram_vga_data_out,
   output logic       vram_vga_ready
);

   localparam int DEPTH = 2 ** $bits(vram_addr_t);

   mem_word_t  mem [DEPTH];
   mem_word_t  cpu_ram_q;
   mem_word_t  vga_ram_q;
   mem_word_t  vga_hold;
   logic [3:0] cpu_ready_dly;

   ////////////////////////////////////////////////////////////
   // cpu port
   ////////////////////////////////////////////////////////////

   // write and registered read with old data on collision
   always_ff @(posedge clk) begin
      if (vram_cpu_req) begin
         if (vram_cpu_write) begin
            mem[vram_cpu_addr] <= vram_cpu_data_in;
         end
         cpu_ram_q <= mem[vram_cpu_addr];
      end
   end

   // output register so the word is valid from the second edge
   always_ff @(posedge clk) begin
      vram_cpu_data_out <= cpu_ram_q;
   end

   // ready is the request level four edges late
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cpu_ready_dly <= '0;
      end else begin
         cpu_ready_dly <= {cpu_ready_dly[2:0], vram_cpu_req};
      end
   end

   assign vram_cpu_ready = cpu_ready_dly[3];

   ////////////////////////////////////////////////////////////
   // display port
   ////////////////////////////////////////////////////////////

   // read only, registered on every edge
   always_ff @(posedge clk) begin
      vga_ram_q <= mem[vram_vga_addr];
   end

   // ready follows req by one edge and hold keeps the last good word
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         vram_vga_ready <= 1'b0;
         vga_hold       <= '0;
      end else begin
         vram_vga_ready <= vram_vga_req;
         if (vram_vga_ready) begin
            vga_hold <= vga_ram_q;
         end
      end
   end

   // fresh ram data while ready and the held word otherwise
   assign vram_vga_data_out = vram_vga_ready ? vga_ram_q : vga_hold;

endmodule

/* ram_controller.sv */
// memory side top level
`timescale 1ns/1ps

module ram_controller import ram_ctrl_pkg::*; #(
   parameter int unsigned RESET_CYCLES = 65535
) (
   input  logic        clk,
   input  logic        reset,
   // reset and calibration
   input  logic        lpddr_reset,
   input  logic        init_calib_complete,
   output logic        dram_sys_rst,
   output logic        calib_done,
   // cpu main memory
   input  sdram_addr_t sdram_addr,
   input  mem_word_t   sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output mem_word_t   sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,
   // controller application interface
   input  logic        app_rdy,
   input  logic        app_wdf_rdy,
   input  mem_word_t   app_rd_data,
   input  logic        app_rd_data_valid,
   output app_addr_t   app_addr,
   output app_cmd_t    app_cmd,
   output logic        app_en,
   output mem_word_t   app_wdf_data,
   output logic        app_wdf_wren,
   // video ram cpu port
   input  vram_addr_t  vram_cpu_addr,
   input  mem_word_t   vram_cpu_data_in,
   input  logic        vram_cpu_req,
   input  logic        vram_cpu_write,
   output mem_word_t   vram_cpu_data_out,
   output logic        vram_cpu_ready,
   // video ram display port
   input  vram_addr_t  vram_vga_addr,
   input  logic        vram_vga_req,
   output mem_word_t   vram_vga_data_out,
   output logic        vram_vga_ready
);

   ////////////////////////////////////////////////////////////
   // controller core reset and calibration
   ////////////////////////////////////////////////////////////

   // app_rdy also feeds the sticky calibration flag
   dram_init_seq #(
      .RESET_CYCLES (RESET_CYCLES)
   ) i_dram_init_seq (
      .clk                 (clk),
      .reset               (reset),
      .lpddr_reset         (lpddr_reset),
      .app_rdy             (app_rdy),
      .init_calib_complete (init_calib_complete),
      .dram_sys_rst        (dram_sys_rst),
      .calib_done          (calib_done)
   );

   ////////////////////////////////////////////////////////////
   // main-memory bridge and video ram
   ////////////////////////////////////////////////////////////

   sdram_port i_sdram_port (
      .clk               (clk),
      .reset             (reset),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .app_rdy           (app_rdy),
      .app_wdf_rdy       (app_wdf_rdy),
      .app_rd_data       (app_rd_data),
      .app_rd_data_valid (app_rd_data_valid),
      .app_addr          (app_addr),
      .app_cmd           (app_cmd),
      .app_en            (app_en),
      .app_wdf_data      (app_wdf_data),
      .app_wdf_wren      (app_wdf_wren)
   );

   vram_dual_port i_vram_dual_port (
      .clk               (clk),
      .reset             (reset),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready)
   );

endmodule

/* dram_app_model.sv */
// ddr3 application interface model
`timescale 1ns/1ps

module dram_app_model import ram_ctrl_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  app_addr_t app_addr,
   input  app_cmd_t  app_cmd,
   input  logic      app_en,
   input  mem_word_t app_wdf_data,
   input  logic      app_wdf_wren,
   output logic      app_rdy,
   output logic      app_wdf_rdy,
   output mem_word_t app_rd_data,
   output logic      app_rd_data_valid,
   output int        protocol_errors
);

   // fitted part, 128k words
   localparam int WORDS = 2 ** 17;

   mem_word_t mem [WORDS];
   mem_word_t rd_word;
   int        rd_wait;
   integer    seed = 32'he483_b156;

   // power-up contents follow the whole word address
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hd0d0_0000 ^ i;
      end
   end

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         app_rdy           <= 1'b0;
         app_wdf_rdy       <= 1'b0;
         app_rd_data       <= '0;
         app_rd_data_valid <= 1'b0;
         rd_wait           <= 0;
         protocol_errors   <= 0;
      end else begin
         // random back-pressure, ready about three cycles in four
         app_rdy           <= ($random(seed) & 3) != 0;
         app_wdf_rdy       <= ($random(seed) & 3) != 0;
         app_rd_data_valid <= 1'b0;
         // read latency countdown
         if (rd_wait != 0) begin
            rd_wait <= rd_wait - 1;
            if (rd_wait == 1) begin
               app_rd_data       <= rd_word;
               app_rd_data_valid <= 1'b1;
            end
         end
         // command accepted on this edge
         if (app_en && app_rdy) begin
            if (app_cmd == APP_CMD_WRITE) begin
               if (!app_wdf_wren || !app_wdf_rdy) begin
                  $display("model: write command accepted without its write data");
                  protocol_errors <= protocol_errors + 1;
               end
               // nothing fitted above the 128k words
               if (app_addr[27:19] == '0) begin
                  mem[app_addr[18:2]] <= app_wdf_data;
               end
            end else begin
               if (rd_wait != 0) begin
                  $display("model: second read issued while one is outstanding");
                  protocol_errors <= protocol_errors + 1;
               end
               rd_word <= mem[app_addr[18:2]];
               rd_wait <= 1 + ($unsigned($random(seed)) % 6);
            end
         end
      end
   end

endmodule

/* ram_controller_tb.sv */
// memory controller testbench
`timescale 1ns/1ps

module ram_controller_tb import ram_ctrl_pkg::*; ();

   localparam int RESET_LEN  = 8;
   localparam int RST_CYC    = 64;
   localparam int RESET_TIME = RESET_LEN + 2 * (RST_CYC + 16);
   localparam int PORT_MAIN  = 0;
   localparam int PORT_VCPU  = 1;
   localparam int PORT_VGA   = 2;

   logic        clk, reset, lpddr_reset, init_calib_complete;
   logic        dram_sys_rst, calib_done;
   sdram_addr_t sdram_addr;
   mem_word_t   sdram_data_in, sdram_data_out;
   logic        sdram_req, sdram_write, sdram_ready, sdram_done;
   logic        app_rdy, app_wdf_rdy, app_rd_data_valid, app_en, app_wdf_wren;
   mem_word_t   app_rd_data, app_wdf_data;
   app_addr_t   app_addr;
   app_cmd_t    app_cmd;
   int          protocol_errors;
   vram_addr_t  vram_cpu_addr, vram_vga_addr;
   mem_word_t   vram_cpu_data_in, vram_cpu_data_out, vram_vga_data_out;
   logic        vram_cpu_req, vram_cpu_write, vram_cpu_ready, vram_vga_req, vram_vga_ready;

   // stimulus table with one column per queue
   int          sel_q [$];
   bit          wr_q [$];
   sdram_addr_t addr_q [$];
   mem_word_t   data_q [$];
   mem_word_t   exp_q [$];
   // reference contents
   mem_word_t   ref_main [2 ** 17];
   mem_word_t   ref_vram [2 ** 15];
   bit          table_ready = 1'b0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   ram_controller #(.RESET_CYCLES(RST_CYC)) i_ram_controller (.*);
   dram_app_model i_dram_app_model (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // checks and bookkeeping
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input mem_word_t actual,
                             input mem_word_t expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic finish_test(input string what, input int errs_before);
      tests_run++;
      if (errors != errs_before) begin
         tests_failed++;
         $display("test %0d %s: FAIL", tests_run, what);
      end else begin
         $display("test %0d %s: ok", tests_run, what);
      end
   endtask

   function automatic string port_name(input int sel);
      if (sel == PORT_MAIN) return "main";
      if (sel == PORT_VCPU) return "vram cpu";
      return "vram vga";
   endfunction

   // expected value from the reference copy and all ones past 128k words
   task automatic add_entry(input int sel, input bit wr, input sdram_addr_t addr,
                            input mem_word_t data);
      mem_word_t exp;
      exp = data;
      if (sel == PORT_MAIN) begin
         if (wr && addr[21:17] == '0) ref_main[addr[16:0]] = data;
         else if (!wr) exp = (addr[21:17] != '0) ? 32'hffff_ffff : ref_main[addr[16:0]];
      end else begin
         if (wr) ref_vram[addr[14:0]] = data;
         else exp = ref_vram[addr[14:0]];
      end
      sel_q.push_back(sel);
      wr_q.push_back(wr);
      addr_q.push_back(addr);
      data_q.push_back(data);
      exp_q.push_back(exp);
   endtask

   ////////////////////////////////////////////////////////////
   // port drivers
   ////////////////////////////////////////////////////////////

   // core reset count and sticky calibration flag over two lpddr_reset pulses
   task automatic reset_sequence();
      int errs;
      int n;
      int pass;
      errs = errors;
      repeat (RESET_LEN) @(posedge clk);
      #1;
      reset = 1'b0;
      for (pass = 0; pass < 2; pass++) begin
         // second pass restarts the core alone after calibration
         if (pass == 1) begin
            lpddr_reset = 1'b1;
            repeat (4) @(posedge clk);
            #1;
            check_bit("dram_sys_rst", dram_sys_rst, 1'b1);
            check_bit("calib_done", calib_done, 1'b0);
         end
         lpddr_reset = 1'b0;
         for (n = 1; n <= RST_CYC; n++) begin
            @(posedge clk);
            #1;
            check_bit("dram_sys_rst", dram_sys_rst, n != RST_CYC);
            if (n != RST_CYC) check_bit("calib_done", calib_done, 1'b0);
         end
         while (!calib_done) begin
            @(posedge clk);
            #1;
         end
      end
      finish_test("reset and calibration", errs);
   endtask

   // level held until the completion which must drop one cycle later
   task automatic main_access(input bit wr, input sdram_addr_t addr, input mem_word_t data,
                              input mem_word_t exp);
      check_bit("sdram_ready", sdram_ready, 1'b0);
      check_bit("sdram_done", sdram_done, 1'b0);
      @(posedge clk);
      #1;
      sdram_addr    = addr;
      sdram_data_in = data;
      sdram_req     = !wr;
      sdram_write   = wr;
      do begin
         @(posedge clk);
         #1;
      end while (!(wr ? sdram_done : sdram_ready));
      if (!wr) check_word("sdram_data_out", sdram_data_out, exp);
      sdram_req   = 1'b0;
      sdram_write = 1'b0;
      @(posedge clk);
      #1;
      check_bit(wr ? "sdram_done" : "sdram_ready", wr ? sdram_done : sdram_ready, 1'b0);
   endtask

   // one-cycle request with ready exactly four edges later
   task automatic vram_cpu_access(input bit wr, input sdram_addr_t addr, input mem_word_t data,
                                  input mem_word_t exp);
      int n;
      @(posedge clk);
      #1;
      vram_cpu_addr    = addr[14:0];
      vram_cpu_data_in = data;
      vram_cpu_req     = 1'b1;
      vram_cpu_write   = wr;
      for (n = 1; n <= 4; n++) begin
         @(posedge clk);
         #1;
         vram_cpu_req   = 1'b0;
         vram_cpu_write = 1'b0;
         check_bit("vram_cpu_ready", vram_cpu_ready, n == 4);
      end
      if (!wr) check_word("vram_cpu_data_out", vram_cpu_data_out, exp);
   endtask

   // ready one cycle after req and the word held once req is gone
   task automatic vga_access(input sdram_addr_t addr, input mem_word_t exp);
      check_bit("vram_vga_ready", vram_vga_ready, 1'b0);
      @(posedge clk);
      #1;
      vram_vga_addr = addr[14:0];
      vram_vga_req  = 1'b1;
      @(posedge clk);
      #1;
      vram_vga_req  = 1'b0;
      vram_vga_addr = ~addr[14:0];
      check_bit("vram_vga_ready", vram_vga_ready, 1'b1);
      check_word("vram_vga_data_out", vram_vga_data_out, exp);
      @(posedge clk);
      #1;
      check_bit("vram_vga_ready", vram_vga_ready, 1'b0);
      check_word("vram_vga_data_out", vram_vga_data_out, exp);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      int i;
      int errs;
      reset               = 1'b1;
      lpddr_reset         = 1'b1;
      init_calib_complete = 1'b0;
      sdram_addr          = '0;
      sdram_data_in       = '0;
      sdram_req           = 1'b0;
      sdram_write         = 1'b0;
      vram_cpu_addr       = '0;
      vram_cpu_data_in    = '0;
      vram_cpu_req        = 1'b0;
      vram_cpu_write      = 1'b0;
      vram_vga_addr       = '0;
      vram_vga_req        = 1'b0;
      // round trip, overwrite, then addresses past the fitted memory
      add_entry(PORT_MAIN, 1, 22'h000010, 32'h1234_5678);
      add_entry(PORT_MAIN, 1, 22'h01abcd, 32'hcafe_f00d);
      add_entry(PORT_MAIN, 0, 22'h000010, '0);
      add_entry(PORT_MAIN, 0, 22'h01abcd, '0);
      add_entry(PORT_MAIN, 1, 22'h000010, 32'h0f1e_2d3c);
      add_entry(PORT_MAIN, 0, 22'h000010, '0);
      add_entry(PORT_MAIN, 1, 22'h200123, 32'hdead_beef);
      add_entry(PORT_MAIN, 0, 22'h200123, '0);
      add_entry(PORT_MAIN, 0, 22'h020000, '0);
      add_entry(PORT_MAIN, 0, 22'h3fffff, '0);
      // video ram through both ports
      add_entry(PORT_VCPU, 1, 22'h001234, 32'h0bad_cafe);
      add_entry(PORT_VCPU, 0, 22'h001234, '0);
      add_entry(PORT_VGA,  0, 22'h001234, '0);
      add_entry(PORT_VCPU, 1, 22'h007fff, 32'h5555_aaaa);
      add_entry(PORT_VGA,  0, 22'h007fff, '0);
      add_entry(PORT_VCPU, 0, 22'h007fff, '0);
      table_ready = 1'b1;
      reset_sequence();
      for (i = 0; i < sel_q.size(); i++) begin
         errs = errors;
         case (sel_q[i])
            PORT_MAIN: main_access(wr_q[i], addr_q[i], data_q[i], exp_q[i]);
            PORT_VCPU: vram_cpu_access(wr_q[i], addr_q[i], data_q[i], exp_q[i]);
            default:   vga_access(addr_q[i], exp_q[i]);
         endcase
         finish_test($sformatf("%s %s addr %h", port_name(sel_q[i]),
                     wr_q[i] ? "write" : "read", addr_q[i]), errs);
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d model protocol errors",
               tests_run, tests_run - tests_failed, tests_failed, errors, protocol_errors);
      if (errors == 0 && tests_failed == 0 && protocol_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // bound from the table length plus the reset sequence
   initial begin
      wait (table_ready);
      repeat (sel_q.size() * 40 + RESET_TIME) @(posedge clk);
      $display("watchdog: the run did not finish within %0d cycles",
               sel_q.size() * 40 + RESET_TIME);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* tb.f */
ram_ctrl_pkg.sv
dram_init_seq.sv
sdram_port.sv
vram_dual_port.sv
ram_controller.sv
dram_app_model.sv
ram_controller_tb.sv
